//--- common/serv_pkg.sv
`default_nettype none

package serv_pkg;

   localparam int XLEN = 32;

   typedef logic [4:0] reg_addr_t;

   // Serial bit position during execute
   typedef logic [4:0] cnt_t;

   typedef enum logic [2:0] {
      OPC_LUI   = 3'd0,
      OPC_IMM   = 3'd1,
      OPC_REG   = 3'd2,
      OPC_STORE = 3'd3,
      OPC_OTHER = 3'd4
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   typedef struct packed {
      opcode_e   opcode;
      alu_op_e   alu_op;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      logic      rd_en;
      logic      op_b_imm;
      // LUI adds the immediate to zero
      logic      rs1_zero;
      logic      store;
   } decode_t;

endpackage

`default_nettype wire

//--- hdl/serv_state.sv
`timescale 1ns/1ps
`default_nettype none

module serv_state import serv_pkg::*; #(
   parameter logic [XLEN-1:0] RESET_PC = '0
) (
   input  wire             clk,
   input  wire             i_reset,
   input  decode_t         i_dec,
   input  wire             i_ibus_ack,
   input  wire             i_dbus_ack,
   output logic [XLEN-1:0] o_ibus_adr,
   output logic            o_ibus_cyc,
   output logic            o_dbus_cyc,
   output cnt_t            o_cnt,
   output logic            o_cnt_en,
   output logic            o_cnt_done
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_FETCH,
      ST_EXEC,
      ST_STORE
   } state_e;

   state_e          state;
   cnt_t            cnt;
   logic [XLEN-1:0] pc;

   assign o_cnt_en   = (state == ST_EXEC);
   assign o_cnt_done = (state == ST_EXEC) && (&cnt);
   assign o_cnt      = cnt;

   // Bus levels straight from the state
   assign o_ibus_cyc = (state == ST_FETCH);
   assign o_dbus_cyc = (state == ST_STORE);
   assign o_ibus_adr = pc;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state <= ST_IDLE;
         cnt   <= '0;
         pc    <= RESET_PC;
      end else begin
         case (state)
            ST_IDLE: begin
               state <= ST_FETCH;
            end
            ST_FETCH: begin
               if (i_ibus_ack) begin
                  state <= ST_EXEC;
                  cnt   <= '0;
               end
            end
            ST_EXEC: begin
               cnt <= cnt + 5'd1;
               if (o_cnt_done) begin
                  if (i_dec.store) begin
                     state <= ST_STORE;
                  end else begin
                     state <= ST_FETCH;
                     pc    <= pc + 32'd4;
                  end
               end
            end
            default: begin
               // Wait for the store to be taken
               if (i_dbus_ack) begin
                  state <= ST_FETCH;
                  pc    <= pc + 32'd4;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/serv_decode.sv
`timescale 1ns/1ps
`default_nettype none

module serv_decode import serv_pkg::*; (
   input  wire             clk,
   input  wire             i_reset,
   input  wire [XLEN-1:0]  i_ibus_rdt,
   input  wire             i_ibus_ack,
   output decode_t         o_dec,
   output logic [XLEN-1:0] o_instr
);

   localparam decode_t DEC_NOP = '{
      opcode: OPC_OTHER, alu_op: ALU_ADD, rd: 5'd0, rs1: 5'd0, rs2: 5'd0,
      rd_en: 1'b0, op_b_imm: 1'b0, rs1_zero: 1'b0, store: 1'b0
   };

   wire [2:0] funct3 = i_ibus_rdt[14:12];
   wire [6:0] funct7 = i_ibus_rdt[31:25];

   decode_t dec_next;
   alu_op_e bool_op;
   logic    f3_ok;

   // ADD, XOR, OR and AND share funct3 between OP and OP-IMM
   always_comb begin
      f3_ok = 1'b1;
      case (funct3)
         3'b000:  bool_op = ALU_ADD;
         3'b100:  bool_op = ALU_XOR;
         3'b110:  bool_op = ALU_OR;
         3'b111:  bool_op = ALU_AND;
         default: begin
            bool_op = ALU_ADD;
            f3_ok   = 1'b0;
         end
      endcase
   end

   always_comb begin
      dec_next     = DEC_NOP;
      dec_next.rd  = i_ibus_rdt[11:7];
      dec_next.rs1 = i_ibus_rdt[19:15];
      dec_next.rs2 = i_ibus_rdt[24:20];
      case (i_ibus_rdt[6:0])
         7'b0110111: begin
            dec_next.opcode   = OPC_LUI;
            dec_next.rs1_zero = 1'b1;
            dec_next.op_b_imm = 1'b1;
         end
         7'b0010011: begin
            if (f3_ok) begin
               dec_next.opcode   = OPC_IMM;
               dec_next.alu_op   = bool_op;
               dec_next.op_b_imm = 1'b1;
            end
         end
         7'b0110011: begin
            if (f3_ok && funct7 == 7'b0000000) begin
               dec_next.opcode = OPC_REG;
               dec_next.alu_op = bool_op;
            end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
               dec_next.opcode = OPC_REG;
               dec_next.alu_op = ALU_SUB;
            end
         end
         7'b0100011: begin
            // SW only
            if (funct3 == 3'b010) begin
               dec_next.opcode   = OPC_STORE;
               dec_next.op_b_imm = 1'b1;
               dec_next.store    = 1'b1;
            end
         end
         default: begin
         end
      endcase
      dec_next.rd_en = (dec_next.opcode inside {OPC_LUI, OPC_IMM, OPC_REG}) &&
                       (dec_next.rd != 5'd0);
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_dec <= DEC_NOP;
      end else if (i_ibus_ack) begin
         o_dec <= dec_next;
      end
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_instr <= i_ibus_rdt;
      end
   end

endmodule

`default_nettype wire

//--- hdl/serv_immdec.sv
`timescale 1ns/1ps
`default_nettype none

module serv_immdec import serv_pkg::*; (
   input  wire            clk,
   input  wire            i_ibus_ack,
   input  wire [XLEN-1:0] i_instr,
   input  decode_t        i_dec,
   input  wire            i_cnt_en,
   output logic           o_imm_bit
);

   logic [XLEN-1:0] imm_full;
   logic [XLEN-1:0] imm_q;
   logic            fresh;

   always_comb begin
      case (i_dec.opcode)
         OPC_LUI:   imm_full = {i_instr[31:12], 12'd0};
         OPC_STORE: imm_full = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
         default:   imm_full = {{20{i_instr[31]}}, i_instr[31:20]};
      endcase
   end

   // Word and decode settle one cycle after the ack, so bit 0 comes straight from them
   assign o_imm_bit = fresh ? imm_full[0] : imm_q[0];

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         fresh <= 1'b1;
      end else if (i_cnt_en) begin
         fresh <= 1'b0;
      end
      if (i_cnt_en) begin
         imm_q <= fresh ? {1'b0, imm_full[XLEN-1:1]} : {1'b0, imm_q[XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

//--- hdl/serv_rf.sv
`timescale 1ns/1ps
`default_nettype none

module serv_rf import serv_pkg::*; (
   input  wire     clk,
   input  decode_t i_dec,
   input  cnt_t    i_cnt,
   input  wire     i_cnt_en,
   input  wire     i_rd_bit,
   output logic    o_rs1_bit,
   output logic    o_rs2_bit
);

   logic [XLEN-1:0] regs [32];

   // x0 is never written, so force its reads
   assign o_rs1_bit = (i_dec.rs1 == 5'd0) ? 1'b0 : regs[i_dec.rs1][i_cnt];
   assign o_rs2_bit = (i_dec.rs2 == 5'd0) ? 1'b0 : regs[i_dec.rs2][i_cnt];

   // Bit cnt is read before it is overwritten, so rd == rs1 sees the old value
   always_ff @(posedge clk) begin
      if (i_cnt_en && i_dec.rd_en) begin
         regs[i_dec.rd][i_cnt] <= i_rd_bit;
      end
   end

endmodule

`default_nettype wire

//--- hdl/serv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module serv_alu import serv_pkg::*; (
   input  wire     clk,
   input  decode_t i_dec,
   input  wire     i_cnt_en,
   input  cnt_t    i_cnt,
   input  wire     i_rs1_bit,
   input  wire     i_rs2_bit,
   input  wire     i_imm_bit,
   output logic    o_rd_bit
);

   wire op_a  = i_dec.rs1_zero ? 1'b0 : i_rs1_bit;
   wire op_b  = i_dec.op_b_imm ? i_imm_bit : i_rs2_bit;
   wire sub   = (i_dec.alu_op == ALU_SUB);
   wire b_add = op_b ^ sub;

   logic carry_q;
   logic carry_in;
   logic sum;
   logic carry_out;

   // Carry preset at bit 0, a one for subtract gives a + ~b + 1
   assign carry_in  = (i_cnt == 5'd0) ? sub : carry_q;
   assign sum       = op_a ^ b_add ^ carry_in;
   assign carry_out = (op_a & b_add) | (op_a & carry_in) | (b_add & carry_in);

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_q <= carry_out;
      end
   end

   always_comb begin
      case (i_dec.alu_op)
         ALU_AND: o_rd_bit = op_a & op_b;
         ALU_OR:  o_rd_bit = op_a | op_b;
         ALU_XOR: o_rd_bit = op_a ^ op_b;
         default: o_rd_bit = sum;
      endcase
   end

endmodule

`default_nettype wire

//--- hdl/serv_bufreg.sv
`timescale 1ns/1ps
`default_nettype none

module serv_bufreg import serv_pkg::*; (
   input  wire             clk,
   input  decode_t         i_dec,
   input  wire             i_cnt_en,
   input  wire             i_adr_bit,
   input  wire             i_rs2_bit,
   output logic [XLEN-1:0] o_dbus_adr,
   output logic [XLEN-1:0] o_dbus_dat
);

   logic shift_en;

   assign shift_en = i_cnt_en && i_dec.store;

   // LSB first in, so after bit 31 both words are in place
   always_ff @(posedge clk) begin
      if (shift_en) begin
         o_dbus_adr <= {i_adr_bit, o_dbus_adr[XLEN-1:1]};
         o_dbus_dat <= {i_rs2_bit, o_dbus_dat[XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

//--- hdl/serv_top.sv
`timescale 1ns/1ps
`default_nettype none

module serv_top import serv_pkg::*; #(
   parameter logic [XLEN-1:0] RESET_PC = '0
) (
   input  wire             clk,
   input  wire             i_reset,
   output wire [XLEN-1:0]  o_ibus_adr,
   output wire             o_ibus_cyc,
   input  wire [XLEN-1:0]  i_ibus_rdt,
   input  wire             i_ibus_ack,
   output wire [XLEN-1:0]  o_dbus_adr,
   output wire [XLEN-1:0]  o_dbus_dat,
   output wire             o_dbus_cyc,
   input  wire             i_dbus_ack
);

   decode_t         dec;
   wire [XLEN-1:0]  instr;
   cnt_t            cnt;
   wire             cnt_en;
   wire             rs1_bit;
   wire             rs2_bit;
   wire             imm_bit;
   wire             rd_bit;

   serv_state #(
      .RESET_PC (RESET_PC)
   ) state_i (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_dec      (dec),
      .i_ibus_ack (i_ibus_ack),
      .i_dbus_ack (i_dbus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_dbus_cyc (o_dbus_cyc),
      .o_cnt      (cnt),
      .o_cnt_en   (cnt_en),
      .o_cnt_done ()
   );

   serv_decode decode_i (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dec      (dec),
      .o_instr    (instr)
   );

   serv_immdec immdec_i (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_instr    (instr),
      .i_dec      (dec),
      .i_cnt_en   (cnt_en),
      .o_imm_bit  (imm_bit)
   );

   serv_rf rf_i (
      .clk       (clk),
      .i_dec     (dec),
      .i_cnt     (cnt),
      .i_cnt_en  (cnt_en),
      .i_rd_bit  (rd_bit),
      .o_rs1_bit (rs1_bit),
      .o_rs2_bit (rs2_bit)
   );

   serv_alu alu_i (
      .clk       (clk),
      .i_dec     (dec),
      .i_cnt_en  (cnt_en),
      .i_cnt     (cnt),
      .i_rs1_bit (rs1_bit),
      .i_rs2_bit (rs2_bit),
      .i_imm_bit (imm_bit),
      .o_rd_bit  (rd_bit)
   );

   // ALU result doubles as the store address for SW
   serv_bufreg bufreg_i (
      .clk        (clk),
      .i_dec      (dec),
      .i_cnt_en   (cnt_en),
      .i_adr_bit  (rd_bit),
      .i_rs2_bit  (rs2_bit),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

endmodule

`default_nettype wire

//--- sim/serv_checker.sv
`timescale 1ns/1ps
`default_nettype none

module serv_checker import serv_pkg::*; #(
   parameter logic [XLEN-1:0] RESET_PC = '0,
   parameter int              N_STORES = 8
) (
   input  wire             clk,
   input  wire             i_reset,
   input  wire [XLEN-1:0]  i_ibus_adr,
   input  wire [XLEN-1:0]  i_ibus_rdt,
   input  wire             i_ibus_cyc,
   input  wire             i_ibus_ack,
   input  wire [XLEN-1:0]  i_dbus_adr,
   input  wire [XLEN-1:0]  i_dbus_dat,
   input  wire             i_dbus_cyc,
   input  wire             i_dbus_ack,
   input  logic [XLEN-1:0] i_exp_adr [N_STORES],
   input  logic [XLEN-1:0] i_exp_dat [N_STORES],
   output int              o_errors,
   output int              o_stores,
   output int              o_fetches
);

   localparam int IW = $clog2(N_STORES);

   // Opcode of the word fetched last
   logic last_store;

   always @(posedge clk) begin
      int              err;
      logic [XLEN-1:0] exp_pc;
      logic [XLEN-1:0] want_adr;
      logic [XLEN-1:0] want_dat;
      err = 0;
      if (i_reset) begin
         o_errors   <= 0;
         o_stores   <= 0;
         o_fetches  <= 0;
         last_store <= 1'b0;
      end else begin
         if (i_ibus_cyc && i_ibus_ack) begin
            exp_pc = RESET_PC + 32'(o_fetches) * 32'd4;
            if (i_ibus_adr != exp_pc) begin
               $display("Mismatch at %0t: o_ibus_adr expected %h, got %h",
                        $time, exp_pc, i_ibus_adr);
               err++;
            end
            o_fetches  <= o_fetches + 1;
            last_store <= (i_ibus_rdt[6:0] == 7'b0100011);
         end
         if (i_dbus_cyc && i_dbus_ack) begin
            if (!last_store) begin
               $display("Error at %0t: data bus cycle for an instruction that is not a store",
                        $time);
               err++;
            end
            if (o_stores >= N_STORES) begin
               $display("Error at %0t: more stores than the program contains", $time);
               err++;
            end else begin
               want_adr = i_exp_adr[o_stores[IW-1:0]];
               want_dat = i_exp_dat[o_stores[IW-1:0]];
               if (i_dbus_adr != want_adr) begin
                  $display("Mismatch at %0t: o_dbus_adr expected %h, got %h",
                           $time, want_adr, i_dbus_adr);
                  err++;
               end
               if (i_dbus_dat != want_dat) begin
                  $display("Mismatch at %0t: o_dbus_dat expected %h, got %h",
                           $time, want_dat, i_dbus_dat);
                  err++;
               end
               $display("store %0d to %h: %s", o_stores, want_adr, (err == 0) ? "ok" : "wrong");
            end
            o_stores <= o_stores + 1;
         end
         o_errors <= o_errors + err;
      end
   end

endmodule

`default_nettype wire

//--- sim/serv_tb.sv
`timescale 1ns/1ps
`default_nettype none

module serv_tb import serv_pkg::*; ();

   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;
   localparam logic [XLEN-1:0] NOP = 32'h0000_0013;
   localparam int PROG_LEN = 25;
   localparam int N_STORES = 8;
   localparam int CYCLE_LIMIT = (PROG_LEN * 40 + N_STORES * 8) * 2;

   logic            clk = 1'b0;
   logic            reset;
   logic [XLEN-1:0] ibus_rdt;
   logic            ibus_ack;
   logic            dbus_ack;
   wire  [XLEN-1:0] ibus_adr;
   wire             ibus_cyc;
   wire  [XLEN-1:0] dbus_adr;
   wire  [XLEN-1:0] dbus_dat;
   wire             dbus_cyc;

   logic [XLEN-1:0] prog [32];
   logic [XLEN-1:0] exp_adr [N_STORES];
   logic [XLEN-1:0] exp_dat [N_STORES];
   logic [31:0]     lfsr = 32'hf330160c;
   logic [1:0]      ibus_wait;
   logic [1:0]      dbus_wait;
   logic            ibus_busy;
   logic            dbus_busy;
   int              errors;
   int              stores;
   int              fetches;
   int              cycles;

   always #5 clk = ~clk;

   function automatic logic lfsr_step();
      logic lsb;
      lsb  = lfsr[0];
      lfsr = lfsr >> 1;
      if (lsb) begin
         lfsr = lfsr ^ 32'h8020_0003;
      end
      return lsb;
   endfunction

   function automatic logic [1:0] rand_delay();
      logic [1:0] d;
      d[0] = lfsr_step();
      d[1] = lfsr_step();
      return d;
   endfunction

   // RV32 encodings
   function automatic logic [31:0] lui_instr(input logic [4:0] rd, input logic [19:0] imm);
      return {imm, rd, 7'b0110111};
   endfunction

   function automatic logic [31:0] op_imm_instr(input logic [2:0] f3, input logic [4:0] rd,
                                                input logic [4:0] rs1, input logic [11:0] imm);
      return {imm, rs1, f3, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] op_reg_instr(input logic [6:0] f7, input logic [2:0] f3,
                                                input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] sw_instr(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
   endfunction

   // Past the end of the program the core runs NOPs
   function automatic logic [XLEN-1:0] fetch_word(input logic [XLEN-1:0] adr);
      logic [XLEN-1:0] idx;
      idx = (adr - RESET_PC) >> 2;
      if (idx < 32'(PROG_LEN)) begin
         return prog[idx[4:0]];
      end else begin
         return NOP;
      end
   endfunction

   function automatic logic program_finished();
      return (stores == N_STORES) && (fetches > PROG_LEN);
   endfunction

   serv_top #(
      .RESET_PC (RESET_PC)
   ) dut_i (
      .clk        (clk),
      .i_reset    (reset),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_cyc (dbus_cyc),
      .i_dbus_ack (dbus_ack)
   );

   serv_checker #(
      .RESET_PC (RESET_PC),
      .N_STORES (N_STORES)
   ) checker_i (
      .clk        (clk),
      .i_reset    (reset),
      .i_ibus_adr (ibus_adr),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_cyc (ibus_cyc),
      .i_ibus_ack (ibus_ack),
      .i_dbus_adr (dbus_adr),
      .i_dbus_dat (dbus_dat),
      .i_dbus_cyc (dbus_cyc),
      .i_dbus_ack (dbus_ack),
      .i_exp_adr  (exp_adr),
      .i_exp_dat  (exp_dat),
      .o_errors   (errors),
      .o_stores   (stores),
      .o_fetches  (fetches)
   );

   // Both bus models, acks after 0 to 3 wait cycles
   always @(posedge clk) begin
      #1;
      if (ibus_ack) begin
         ibus_ack = 1'b0;
      end else if (ibus_cyc) begin
         if (!ibus_busy) begin
            ibus_wait = rand_delay();
            ibus_busy = 1'b1;
         end
         if (ibus_wait == 2'd0) begin
            ibus_ack  = 1'b1;
            ibus_rdt  = fetch_word(ibus_adr);
            ibus_busy = 1'b0;
         end else begin
            ibus_wait = ibus_wait - 2'd1;
         end
      end
      if (dbus_ack) begin
         dbus_ack = 1'b0;
      end else if (dbus_cyc) begin
         if (!dbus_busy) begin
            dbus_wait = rand_delay();
            dbus_busy = 1'b1;
         end
         if (dbus_wait == 2'd0) begin
            dbus_ack  = 1'b1;
            dbus_busy = 1'b0;
         end else begin
            dbus_wait = dbus_wait - 2'd1;
         end
      end
   end

   initial begin : main
      logic [XLEN-1:0] x1;
      logic [XLEN-1:0] x3;
      logic [XLEN-1:0] x6;
      logic [XLEN-1:0] x9;
      logic [XLEN-1:0] base;
      reset     = 1'b1;
      ibus_rdt  = '0;
      ibus_ack  = 1'b0;
      dbus_ack  = 1'b0;
      ibus_busy = 1'b0;
      dbus_busy = 1'b0;
      ibus_wait = 2'd0;
      dbus_wait = 2'd0;

      prog[0]  = lui_instr(5'd1, 20'h12345);
      prog[1]  = op_imm_instr(3'b000, 5'd2, 5'd0, 12'h200);
      prog[2]  = sw_instr(5'd1, 5'd2, 12'h000);
      prog[3]  = op_imm_instr(3'b000, 5'd3, 5'd1, 12'hffb);
      prog[4]  = op_reg_instr(7'h00, 3'b000, 5'd4, 5'd3, 5'd1);
      prog[5]  = lui_instr(5'd9, 20'hf0000);
      prog[6]  = op_reg_instr(7'h00, 3'b000, 5'd5, 5'd9, 5'd9);
      prog[7]  = sw_instr(5'd4, 5'd2, 12'h004);
      prog[8]  = sw_instr(5'd5, 5'd2, 12'hff8);
      prog[9]  = op_imm_instr(3'b000, 5'd6, 5'd0, 12'h007);
      prog[10] = op_reg_instr(7'h20, 3'b000, 5'd7, 5'd6, 5'd3);
      prog[11] = sw_instr(5'd7, 5'd2, 12'h008);
      prog[12] = op_reg_instr(7'h00, 3'b111, 5'd8, 5'd1, 5'd3);
      prog[13] = op_reg_instr(7'h00, 3'b110, 5'd10, 5'd3, 5'd6);
      prog[14] = op_reg_instr(7'h00, 3'b100, 5'd11, 5'd8, 5'd10);
      prog[15] = sw_instr(5'd11, 5'd2, 12'h00c);
      prog[16] = op_imm_instr(3'b111, 5'd12, 5'd3, 12'h0f0);
      prog[17] = op_imm_instr(3'b110, 5'd13, 5'd12, 12'hf00);
      prog[18] = op_imm_instr(3'b100, 5'd14, 5'd13, 12'h555);
      prog[19] = sw_instr(5'd14, 5'd2, 12'h010);
      // x0 write, then rd == rs1, then LW x6 which is not supported and must not write
      prog[20] = op_imm_instr(3'b000, 5'd0, 5'd1, 12'h001);
      prog[21] = op_reg_instr(7'h00, 3'b000, 5'd6, 5'd6, 5'd6);
      prog[22] = 32'h0001_2303;
      prog[23] = sw_instr(5'd0, 5'd2, 12'h014);
      prog[24] = sw_instr(5'd6, 5'd2, 12'h018);

      x1   = {20'h12345, 12'h000};
      x3   = x1 + {{20{1'b1}}, 12'hffb};
      x6   = 32'd7;
      x9   = {20'hf0000, 12'h000};
      base = 32'h0000_0200;
      exp_adr[0] = base;
      exp_dat[0] = x1;
      exp_adr[1] = base + 32'd4;
      exp_dat[1] = x3 + x1;
      exp_adr[2] = base - 32'd8;
      exp_dat[2] = x9 + x9;
      exp_adr[3] = base + 32'd8;
      exp_dat[3] = x6 - x3;
      exp_adr[4] = base + 32'd12;
      exp_dat[4] = (x1 & x3) ^ (x3 | x6);
      exp_adr[5] = base + 32'd16;
      exp_dat[5] = ((x3 & 32'h0000_00f0) | 32'hffff_ff00) ^ 32'h0000_0555;
      exp_adr[6] = base + 32'd20;
      exp_dat[6] = '0;
      exp_adr[7] = base + 32'd24;
      exp_dat[7] = x6 + x6;

      repeat (3) @(posedge clk);
      #1;
      reset  = 1'b0;
      cycles = 0;
      while (!program_finished() && cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles++;
      end

      $display("Counts: %0d of %0d stores, %0d fetches, %0d errors",
               stores, N_STORES, fetches, errors);
      if (!program_finished()) begin
         $display("Timeout: the program did not finish within %0d cycles", CYCLE_LIMIT);
      end
      if (program_finished() && errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- serv.f
common/serv_pkg.sv
hdl/serv_state.sv
hdl/serv_decode.sv
hdl/serv_immdec.sv
hdl/serv_rf.sv
hdl/serv_alu.sv
hdl/serv_bufreg.sv
hdl/serv_top.sv
sim/serv_checker.sv
sim/serv_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f serv.f --top-module serv_tb -o serv_sim \
   && ./obj_dir/serv_sim > sim.log 2>&1 \
   || echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0
